//--- all.f
bpu_pkg.sv
history_unit.sv
pht_bank.sv
bpu_stats_wb.sv
bpu_top.sv
tb_bpu.sv

//--- Bender.yml
package:
  name: bpu

dependencies: {}

sources:
  - files:
      - bpu_pkg.sv
      - history_unit.sv
      - pht_bank.sv
      - bpu_stats_wb.sv
      - bpu_top.sv
  - target: test
    files:
      - tb_bpu.sv

//--- tb_bpu.sv
`default_nettype none

module tb_bpu
    import bpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PC_W        = 3;
    localparam int HIST_W      = 2;
    localparam int BANK_W      = 2;
    localparam int NUM_BANKS   = 2 ** BANK_W;
    localparam int NUM_ENTRIES = 2 ** (PC_W + HIST_W);
    localparam int ACK_LIMIT   = 16;
    // About 1000 cycles of tests, with ample margin.
    localparam int MAX_CYCLES  = 4000;

    logic              clk;
    logic              rst;
    logic [31:0]       pc_to_predict;
    logic              prediction;
    logic [31:0]       pc_to_update;
    logic              is_branch;
    logic              branch_taken;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [WB_AW-1:0]  wb_adr;
    logic [WB_DW-1:0]  wb_dat_w;
    logic [WB_DW-1:0]  wb_dat_r;
    logic              wb_ack;

    // Reference model state.
    logic [1:0]        model_ctr [NUM_BANKS][NUM_ENTRIES];
    logic [HIST_W-1:0] model_ghr;
    int unsigned       model_branches;
    int unsigned       model_mispredicts;

    int                errors;
    int                checks;
    int                cycles;
    logic [15:0]       lfsr_state;

    bpu_top #(.PC_W(PC_W), .HIST_W(HIST_W), .BANK_W(BANK_W)) i_dut (
        .clk, .rst, .pc_to_predict, .prediction, .pc_to_update, .is_branch,
        .branch_taken, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------------

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [WB_AW-1:0] pht_addr(input int bank, input int entry);
        bpu_addr_u a;
        a = '0;
        a.pht.pht_sel = 1'b1;
        a.pht.bank    = PHT_BANK_FW'(bank);
        a.pht.entry   = PHT_ENTRY_FW'(entry);
        return a;
    endfunction

    function automatic logic [WB_AW-1:0] csr_addr(input logic [1:0] sel);
        bpu_addr_u a;
        a = '0;
        a.csr.reg_sel = sel;
        return a;
    endfunction

    // Entry is the history above the PC bits that follow the bank bits.
    function automatic int model_entry(input logic [31:0] pc);
        return int'({model_ghr, pc[BANK_W +: PC_W]});
    endfunction

    function automatic void model_update(input logic [31:0] pc, input logic taken);
        int b;
        int e;
        b = int'(pc[BANK_W-1:0]);
        e = model_entry(pc);
        model_branches++;
        if (model_ctr[b][e][1] != taken) begin
            model_mispredicts++;
        end
        if (taken && model_ctr[b][e] != 2'd3) begin
            model_ctr[b][e] = model_ctr[b][e] + 2'd1;
        end else if (!taken && model_ctr[b][e] != 2'd0) begin
            model_ctr[b][e] = model_ctr[b][e] - 2'd1;
        end
        model_ghr = HIST_W'({model_ghr, taken});
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic branch_update(input logic [31:0] pc, input logic taken);
        pc_to_update = pc;
        is_branch    = 1'b1;
        branch_taken = taken;
        @(posedge clk);
        #5;
        model_update(pc, taken);
        is_branch = 1'b0;
    endtask

    task automatic check_predict(input logic [31:0] pc);
        logic exp;
        pc_to_predict = pc;
        #10;
        exp = model_ctr[int'(pc[BANK_W-1:0])][model_entry(pc)][1];
        check_val("prediction", 32'(prediction), 32'(exp));
        @(posedge clk);
        #5;
    endtask

    // One access; ack must come after one cycle and last one cycle.
    task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            @(posedge clk);
            #5;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        checks++;
        assert (wb_ack) else begin
            errors++;
            $display("Error: no Wishbone ack within %0d cycles, address 0x%h", ACK_LIMIT, adr);
        end
        check_val("wb_ack latency", 32'(waited), 32'd1);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #5;
        checks++;
        assert (!wb_ack) else begin
            errors++;
            $display("Error: Wishbone ack held high for a second cycle, address 0x%h", adr);
        end
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] wdat);
        logic [WB_DW-1:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic check_ctr(input int bank, input int entry);
        logic [WB_DW-1:0] d;
        wb_read(pht_addr(bank, entry), d);
        check_val("dbg_ctr", d, 32'(model_ctr[bank][entry]));
    endtask

    task automatic check_csr(input string name, input logic [1:0] sel,
                             input logic [31:0] exp);
        logic [WB_DW-1:0] d;
        wb_read(csr_addr(sel), d);
        check_val(name, d, exp);
    endtask

    // ------------------------------------------------------------------------
    // Tests.
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                check_ctr(b, e);
            end
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            check_predict(32'(i));
        end
        check_csr("branches", CSR_BRANCHES, 32'd0);
        check_csr("mispredicts", CSR_MISPREDICTS, 32'd0);
        check_csr("ghr", CSR_GHR, 32'd0);
    endtask

    task automatic test_saturation();
        logic [31:0]      pc;
        logic [WB_DW-1:0] d;
        pc = 32'h0000_0014;
        repeat (6) branch_update(pc, 1'b1);
        wb_read(pht_addr(0, model_entry(pc)), d);
        check_val("dbg_ctr", d, 32'd3);
        check_predict(pc);
        repeat (6) branch_update(pc, 1'b0);
        wb_read(pht_addr(0, model_entry(pc)), d);
        check_val("dbg_ctr", d, 32'd0);
        check_predict(pc);
    endtask

    task automatic test_alternating();
        logic [31:0] pc;
        logic        dir;
        pc = 32'h0000_0021;
        for (int i = 0; i < 16; i++) begin
            branch_update(pc, (i % 2) == 0);
        end
        for (int i = 16; i < 24; i++) begin
            dir = ((i % 2) == 0);
            pc_to_predict = pc;
            #10;
            check_val("prediction", 32'(prediction), 32'(dir));
            @(posedge clk);
            #5;
            branch_update(pc, dir);
        end
    endtask

    task automatic test_bank_isolation();
        logic [31:0] pa;
        logic [31:0] pb;
        pa = 32'h0000_0048;
        pb = 32'h0000_004A;
        repeat (4) branch_update(pa, 1'b1);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            check_ctr(2, e);
            check_ctr(0, e);
        end
        check_predict(pa);
        check_predict(pb);
    endtask

    task automatic test_random_stats();
        wb_write(csr_addr(CSR_BRANCHES), '0);
        model_branches    = 0;
        model_mispredicts = 0;
        repeat (200) begin
            branch_update(rand_bits(7), rand_bits(1) == 32'd1);
        end
        check_csr("branches", CSR_BRANCHES, 32'd200);
        check_csr("mispredicts", CSR_MISPREDICTS, model_mispredicts);
        wb_write(csr_addr(CSR_BRANCHES), 32'h1);
        model_branches    = 0;
        model_mispredicts = 0;
        check_csr("branches", CSR_BRANCHES, 32'd0);
        check_csr("mispredicts", CSR_MISPREDICTS, 32'd0);
    endtask

    task automatic test_wishbone_ghr();
        repeat (20) begin
            branch_update(rand_bits(7), rand_bits(1) == 32'd1);
            check_csr("ghr", CSR_GHR, 32'(model_ghr));
        end
        // Unused select, and writes that must change nothing.
        check_csr("unused register", 2'd3, 32'd0);
        wb_write(csr_addr(CSR_GHR), 32'hFFFF_FFFF);
        wb_write(csr_addr(CSR_MISPREDICTS), 32'hFFFF_FFFF);
        check_csr("ghr", CSR_GHR, 32'(model_ghr));
        check_csr("branches", CSR_BRANCHES, model_branches);
        check_csr("mispredicts", CSR_MISPREDICTS, model_mispredicts);
    endtask

    initial begin
        rst           = 1'b1;
        pc_to_predict = '0;
        pc_to_update  = '0;
        is_branch     = 1'b0;
        branch_taken  = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        lfsr_state    = 16'd22587;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                model_ctr[b][e] = CTR_RESET;
            end
        end
        model_ghr         = '0;
        model_branches    = 0;
        model_mispredicts = 0;

        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        test_reset_state();
        test_saturation();
        test_alternating();
        test_bank_isolation();
        test_random_stats();
        test_wishbone_ghr();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bpu_top.sv
`default_nettype none

module bpu_top
    import bpu_pkg::*;
#(
    parameter int PC_W   = 3,
    parameter int HIST_W = 2,
    parameter int BANK_W = 2
) (
    input  wire                           clk,
    input  wire                           rst,

    input  wire  [31:0]                   pc_to_predict,
    output logic                          prediction,

    input  wire  [31:0]                   pc_to_update,
    input  wire                           is_branch,
    input  wire                           branch_taken,

    input  wire                           wb_cyc,
    input  wire                           wb_stb,
    input  wire                           wb_we,
    input  wire  [WB_AW-1:0]              wb_adr,
    input  wire  [WB_DW-1:0]              wb_dat_w,
    output logic [WB_DW-1:0]              wb_dat_r,
    output logic                          wb_ack
);

    localparam int IDX_W     = PC_W + HIST_W;
    localparam int NUM_BANKS = 2 ** BANK_W;

    // Geometry must fit the counter view of the address.
    if (!bpu_params_fit(PC_W, HIST_W, BANK_W)) begin : g_param_check
        $error("bpu_top: PC_W, HIST_W or BANK_W do not fit the address map");
    end

    logic [HIST_W-1:0]      ghr;
    logic [BANK_W-1:0]      pred_bank;
    logic [BANK_W-1:0]      upd_bank;
    logic [IDX_W-1:0]       pred_entry;
    logic [IDX_W-1:0]       upd_entry;
    logic [IDX_W-1:0]       dbg_entry;
    logic [NUM_BANKS-1:0]   upd_en;
    logic                   upd_valid;
    logic                   upd_taken;
    logic [NUM_BANKS-1:0]   pred_dir_all;
    logic [NUM_BANKS-1:0]   upd_dir_all;
    logic [2*NUM_BANKS-1:0] dbg_ctr_all;

    history_unit #(.PC_W(PC_W), .HIST_W(HIST_W), .BANK_W(BANK_W)) i_history (
        .clk, .rst, .pc_to_predict, .pc_to_update, .is_branch, .branch_taken,
        .ghr, .pred_bank, .upd_bank, .pred_entry, .upd_entry, .upd_en,
        .upd_valid, .upd_taken
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        pht_bank #(.PC_W(PC_W), .HIST_W(HIST_W)) i_pht (
            .clk, .rst, .pred_entry, .upd_entry,
            .upd_en(upd_en[b]), .upd_taken, .dbg_entry,
            .pred_dir(pred_dir_all[b]), .upd_dir(upd_dir_all[b]),
            .dbg_ctr(dbg_ctr_all[2*b +: 2])
        );
    end

    bpu_stats_wb #(.PC_W(PC_W), .HIST_W(HIST_W), .BANK_W(BANK_W)) i_stats (
        .clk, .rst, .pred_bank, .upd_bank, .upd_valid, .upd_taken, .ghr,
        .pred_dir_all, .upd_dir_all, .dbg_ctr_all,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .prediction, .dbg_entry, .wb_dat_r, .wb_ack
    );

endmodule

`default_nettype wire

//--- bpu_stats_wb.sv
`default_nettype none

module bpu_stats_wb
    import bpu_pkg::*;
#(
    parameter int PC_W   = 3,
    parameter int HIST_W = 2,
    parameter int BANK_W = 2
) (
    input  wire                           clk,
    input  wire                           rst,

    // From the history unit.
    input  wire  [BANK_W-1:0]             pred_bank,
    input  wire  [BANK_W-1:0]             upd_bank,
    input  wire                           upd_valid,
    input  wire                           upd_taken,
    input  wire  [HIST_W-1:0]             ghr,

    // From the banks, one slice per bank.
    input  wire  [(2**BANK_W)-1:0]        pred_dir_all,
    input  wire  [(2**BANK_W)-1:0]        upd_dir_all,
    input  wire  [2*(2**BANK_W)-1:0]      dbg_ctr_all,

    // Wishbone classic slave.
    input  wire                           wb_cyc,
    input  wire                           wb_stb,
    input  wire                           wb_we,
    input  wire  [WB_AW-1:0]              wb_adr,
    input  wire  [WB_DW-1:0]              wb_dat_w,

    output logic                          prediction,
    output logic [PC_W+HIST_W-1:0]        dbg_entry,
    output logic [WB_DW-1:0]              wb_dat_r,
    output logic                          wb_ack
);

    localparam int IDX_W = PC_W + HIST_W;

    bpu_addr_u         adr;
    logic [BANK_W-1:0] dbg_bank;
    logic              dbg_hit;
    logic [1:0]        dbg_ctr;

    logic              mispredict;
    logic [31:0]       branches;
    logic [31:0]       mispredicts;

    logic              wb_req;
    logic              stats_clr;
    logic [WB_DW-1:0]  rd_data;

    // ------------------------------------------------------------------------
    // Prediction and statistics.
    // ------------------------------------------------------------------------

    assign prediction = pred_dir_all[pred_bank];

    // Compare against the counter as it was before training.
    assign mispredict = upd_valid && (upd_dir_all[upd_bank] != upd_taken);

    // Clear takes priority over a same-cycle update.
    always_ff @(posedge clk) begin
        if (rst || stats_clr) begin
            branches    <= '0;
            mispredicts <= '0;
        end else if (upd_valid) begin
            branches <= branches + 32'd1;
            if (mispredict) begin
                mispredicts <= mispredicts + 32'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Address decode.
    // ------------------------------------------------------------------------

    assign adr = wb_adr;

    assign dbg_bank  = adr.pht.bank[BANK_W-1:0];
    assign dbg_entry = adr.pht.entry[IDX_W-1:0];
    assign dbg_ctr   = dbg_ctr_all[{dbg_bank, 1'b0} +: 2];

    // Bank or entry past the table reads as zero.
    assign dbg_hit = ((adr.pht.bank >> BANK_W) == '0) && ((adr.pht.entry >> IDX_W) == '0);

    always_comb begin
        rd_data = '0;
        if (adr.pht.pht_sel) begin
            if (dbg_hit) begin
                rd_data = WB_DW'(dbg_ctr);
            end
        end else begin
            case (adr.csr.reg_sel)
                CSR_BRANCHES:    rd_data = branches;
                CSR_MISPREDICTS: rd_data = mispredicts;
                CSR_GHR:         rd_data = WB_DW'(ghr);
                default:         rd_data = '0;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Wishbone handshake.
    // ------------------------------------------------------------------------

    assign wb_req    = wb_cyc && wb_stb && !wb_ack;
    assign stats_clr = wb_req && wb_we && !adr.csr.pht_sel && (adr.csr.reg_sel == CSR_BRANCHES);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

    // Address and direction must be defined in a request.
    a_req_known: assert property (
        @(posedge clk) disable iff (rst)
        wb_req |-> !$isunknown({wb_we, wb_adr})
    );

    // Master must present defined write data.
    a_wr_data_known: assert property (
        @(posedge clk) disable iff (rst)
        (wb_req && wb_we) |-> !$isunknown(wb_dat_w)
    );

endmodule

`default_nettype wire

//--- pht_bank.sv
`default_nettype none

module pht_bank
    import bpu_pkg::*;
#(
    parameter int PC_W   = 3,
    parameter int HIST_W = 2
) (
    input  wire                           clk,
    input  wire                           rst,

    // Prediction lookup.
    input  wire  [PC_W+HIST_W-1:0]        pred_entry,
    output logic                          pred_dir,

    // Training.
    input  wire  [PC_W+HIST_W-1:0]        upd_entry,
    input  wire                           upd_en,
    input  wire                           upd_taken,
    output logic                          upd_dir,

    // Host read port.
    input  wire  [PC_W+HIST_W-1:0]        dbg_entry,
    output logic [1:0]                    dbg_ctr
);

    localparam int IDX_W       = PC_W + HIST_W;
    localparam int NUM_ENTRIES = 2 ** IDX_W;

    logic [1:0] ctr [NUM_ENTRIES];

    logic [1:0] upd_cur;
    logic [1:0] upd_nxt;

    // ------------------------------------------------------------------------
    // Read ports.
    // ------------------------------------------------------------------------

    assign pred_dir = ctr[pred_entry][1];
    assign dbg_ctr  = ctr[dbg_entry];

    // Value before this cycle's update.
    assign upd_cur = ctr[upd_entry];
    assign upd_dir = upd_cur[1];

    // ------------------------------------------------------------------------
    // Saturating 2-bit counter step.
    // ------------------------------------------------------------------------

    always_comb begin
        if (upd_taken) begin
            if (upd_cur == CTR_MAX) begin
                upd_nxt = CTR_MAX;
            end else begin
                upd_nxt = upd_cur + 2'd1;
            end
        end else begin
            if (upd_cur == 2'd0) begin
                upd_nxt = 2'd0;
            end else begin
                upd_nxt = upd_cur - 2'd1;
            end
        end
    end

    // All counters start weakly not taken.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                ctr[i] <= CTR_RESET;
            end
        end else if (upd_en) begin
            ctr[upd_entry] <= upd_nxt;
        end
    end

endmodule

`default_nettype wire

//--- history_unit.sv
`default_nettype none

module history_unit #(
    parameter int PC_W   = 3,
    parameter int HIST_W = 2,
    parameter int BANK_W = 2
) (
    input  wire                           clk,
    input  wire                           rst,

    input  wire  [31:0]                   pc_to_predict,
    input  wire  [31:0]                   pc_to_update,
    input  wire                           is_branch,
    input  wire                           branch_taken,

    output logic [HIST_W-1:0]             ghr,
    output logic [BANK_W-1:0]             pred_bank,
    output logic [BANK_W-1:0]             upd_bank,
    output logic [PC_W+HIST_W-1:0]        pred_entry,
    output logic [PC_W+HIST_W-1:0]        upd_entry,
    output logic [(2**BANK_W)-1:0]        upd_en,
    output logic                          upd_valid,
    output logic                          upd_taken
);

    // ------------------------------------------------------------------------
    // Global history register.
    // ------------------------------------------------------------------------

    // Newest outcome enters at bit 0.
    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (is_branch) begin
            ghr <= HIST_W'({ghr, branch_taken});
        end
    end

    // ------------------------------------------------------------------------
    // Index forming.
    // ------------------------------------------------------------------------

    // Low PC bits pick the bank.
    assign pred_bank = pc_to_predict[BANK_W-1:0];
    assign upd_bank  = pc_to_update[BANK_W-1:0];

    // History above the PC bits, pre-shift history for both.
    assign pred_entry = {ghr, pc_to_predict[BANK_W +: PC_W]};
    assign upd_entry  = {ghr, pc_to_update[BANK_W +: PC_W]};

    // One write enable per bank.
    always_comb begin
        upd_en = '0;
        if (is_branch) begin
            upd_en[upd_bank] = 1'b1;
        end
    end

    assign upd_valid = is_branch;
    assign upd_taken = branch_taken;

    // A branch must name a known bank.
    a_upd_bank_known: assert property (
        @(posedge clk) disable iff (rst)
        is_branch |-> !$isunknown(upd_bank)
    );

endmodule

`default_nettype wire

//--- bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // ------------------------------------------------------------------------
    // Wishbone bus widths.
    // ------------------------------------------------------------------------
    localparam int WB_DW = 32;
    localparam int WB_AW = 16;

    // Field widths of the word address.
    localparam int CSR_SEL_FW   = 2;
    localparam int PHT_BANK_FW  = 4;
    localparam int PHT_ENTRY_FW = WB_AW - 1 - PHT_BANK_FW;

    // ------------------------------------------------------------------------
    // Counter encoding.
    // ------------------------------------------------------------------------
    localparam logic [1:0] CTR_RESET = 2'd1;
    localparam logic [1:0] CTR_MAX   = 2'd3;

    // Statistics register selects.
    localparam logic [CSR_SEL_FW-1:0] CSR_BRANCHES    = 2'd0;
    localparam logic [CSR_SEL_FW-1:0] CSR_MISPREDICTS = 2'd1;
    localparam logic [CSR_SEL_FW-1:0] CSR_GHR         = 2'd2;

    // Word address, top bit picks register space or counter space.
    typedef union packed {
        struct packed {
            logic                               pht_sel;
            logic [WB_AW-CSR_SEL_FW-2:0]        rsvd;
            logic [CSR_SEL_FW-1:0]              reg_sel;
        } csr;
        struct packed {
            logic                               pht_sel;
            logic [PHT_BANK_FW-1:0]             bank;
            logic [PHT_ENTRY_FW-1:0]            entry;
        } pht;
    } bpu_addr_u;

    // True when a predictor geometry fits the counter view of the address.
    function automatic bit bpu_params_fit(int pc_w, int hist_w, int bank_w);
        return (pc_w >= 1) && (hist_w >= 1) && (bank_w >= 1)
            && (bank_w <= PHT_BANK_FW)
            && (pc_w + hist_w <= PHT_ENTRY_FW);
    endfunction

endpackage

`default_nettype wire
